// File: lc3Core.f
lc3Pkg.sv
busPkg.sv
regFile.sv
aluUnit.sv
datapath.sv
controlFsm.sv
memBridge.sv
lc3Core.sv
lc3Checker.sv
lc3CoreTb.sv

// File: lc3CorePatterns.txt
// words at 0000 are the step bound then the expected LED value then the write count
// pairs from 0010 are the expected writes as address then data in bus order
// the program image starts at 3000 and its two data words sit at 3030
@0000
0030 0A5C 000C
@0010
3040 1324
3041 0030
3042 122F
3043 0004
3044 EDCB
3045 00F0
3048 0003
3049 0002
304A 0001
3046 122F
3047 1234
304B EDCD
@3000
222F 242F           // LD R1 and LD R2 from the data words
1642 363C           // ADD R3 R1 R2 then ST R3
5842 383B           // AND R4 R1 R2 then ST R4
1A7B 3A3A           // ADD R5 R1 #-5 then ST R5
5C6F 3C39           // AND R6 R1 #15 then ST R6
9E7F 3E38           // NOT R7 R1 then ST R7
E033 6631 7605      // LEA R0 then LDR R3 R0 #-15 then STR R3 R0 #5
54A0 14A3 E836      // clear R2 and set it to 3 then LEA R4 to 3048
7500 1921 14BF 03FC // loop body with STR then two ADDs then BRp back
0401 3E2E           // BRz taken over a store
0801 3A2C           // BRn not taken so the store happens
EC02 C180 3E2A      // LEA R6 then JMP R6 over a store
3229 673E 16C7 362A // ST R1 then LDR of a loop word then ADD and ST
DA5C                // PAUSE with LED value A5C
@3030
1234 00F0

// File: lc3CoreTb.sv
module lc3CoreTb import lc3Pkg::*, busPkg::*; ();

    timeunit 1ns;
    timeprecision 1ns;

    localparam string PatternFile = "lc3CorePatterns.txt";
    // layout of the pattern image below the program
    localparam int HeaderAddr = 0;
    localparam int WritesAddr = 16;

    logic        Clk = 1'b0;
    logic        rstN;
    axiReq_t     axiReq;
    axiRsp_t     axiRsp;
    logic [11:0] led;
    logic        halted;

    word_t       mem [0:65535];
    logic [11:0] expLed;
    int          stepBound;
    int          cycleLimit;
    int          cycles = 0;
    logic        timedOut = 1'b0;
    logic [15:0] lfsr = 16'd62803;

    logic        checkDone;
    int          writeErrors;
    int          ledErrors;
    int          busErrors;

    // slave state
    logic [1:0]  arDelay;
    logic [1:0]  rDelay;
    logic [1:0]  awDelay;
    logic [1:0]  wDelay;
    logic [1:0]  bDelay;
    word_t       readAddr;
    word_t       writeAddr;
    word_t       writeData;
    logic        readPending;
    logic        awGot;
    logic        wGot;

    lc3Core dut_i (
        .Clk    (Clk),
        .rstN   (rstN),
        .axiReq (axiReq),
        .axiRsp (axiRsp),
        .led    (led),
        .halted (halted)
    );

    lc3Checker check_i (
        .Clk         (Clk),
        .rstN        (rstN),
        .axiReq      (axiReq),
        .axiRsp      (axiRsp),
        .led         (led),
        .halted      (halted),
        .expLed      (expLed),
        .done        (checkDone),
        .writeErrors (writeErrors),
        .ledErrors   (ledErrors),
        .busErrors   (busErrors)
    );

    always #50 Clk = ~Clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] nextLfsr(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // two fresh bits give a delay of 0 to 3 cycles
    task automatic takeDelay(output logic [1:0] d);
        lfsr = nextLfsr(lfsr);
        d[0] = lfsr[0];
        lfsr = nextLfsr(lfsr);
        d[1] = lfsr[0];
    endtask

    initial begin
        int writeCount;
        rstN   <= 1'b0;
        axiRsp <= '0;
        $readmemh(PatternFile, mem);
        if ($isunknown(mem[HeaderAddr])) begin
            $display("pattern file %s is missing or has no header", PatternFile);
        end
        stepBound  = int'(mem[HeaderAddr]);
        expLed     = mem[HeaderAddr + 1][11:0];
        writeCount = int'(mem[HeaderAddr + 2]);
        // longest instruction with two accesses at the maximum delay fits in 30
        cycleLimit = stepBound * 30 + 100;
        for (int i = 0; i < writeCount; i++) begin
            check_i.addExpectedWrite(mem[WritesAddr + 2 * i], mem[WritesAddr + 2 * i + 1]);
        end
        repeat (5) @(posedge Clk);
        rstN <= 1'b1;
        while (!checkDone && !timedOut) begin
            @(posedge Clk);
        end
        $display("errors: writes %0d, led %0d, bus %0d, timeout %0d",
                 writeErrors, ledErrors, busErrors, timedOut);
        if (!timedOut && writeErrors + ledErrors + busErrors == 0) begin
            $display("Test passed");
        end else begin
            if (timedOut) begin
                $display("core did not halt within %0d cycles", cycleLimit);
            end
            $display("Test failed");
        end
        $finish;
    end

    always @(posedge Clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            timedOut <= 1'b1;
        end
    end

    // AXI4-Lite slave, ready and valid are pulsed after a random wait
    always @(posedge Clk) begin
        logic [1:0] d;
        if (!rstN) begin
            axiRsp      <= '0;
            readPending <= 1'b0;
            awGot       <= 1'b0;
            wGot        <= 1'b0;
            takeDelay(d);
            arDelay <= d;
            takeDelay(d);
            rDelay <= d;
            takeDelay(d);
            awDelay <= d;
            takeDelay(d);
            wDelay <= d;
            takeDelay(d);
            bDelay <= d;
        end else begin
            // valid is held until the handshake, so ready high means a transfer
            if (axiRsp.arready) begin
                axiRsp.arready <= 1'b0;
                readAddr       <= axiReq.araddr;
                readPending    <= 1'b1;
                takeDelay(d);
                arDelay <= d;
            end else if (axiReq.arvalid) begin
                if (arDelay == 2'd0) begin
                    axiRsp.arready <= 1'b1;
                end else begin
                    arDelay <= arDelay - 2'd1;
                end
            end
            if (axiRsp.rvalid) begin
                if (axiReq.rready) begin
                    axiRsp.rvalid <= 1'b0;
                    takeDelay(d);
                    rDelay <= d;
                end
            end else if (readPending) begin
                if (rDelay == 2'd0) begin
                    axiRsp.rvalid <= 1'b1;
                    axiRsp.rdata  <= mem[readAddr];
                    axiRsp.rresp  <= AxiRespOkay;
                    readPending   <= 1'b0;
                end else begin
                    rDelay <= rDelay - 2'd1;
                end
            end
            if (axiRsp.awready) begin
                axiRsp.awready <= 1'b0;
                writeAddr      <= axiReq.awaddr;
                awGot          <= 1'b1;
                takeDelay(d);
                awDelay <= d;
            end else if (axiReq.awvalid) begin
                if (awDelay == 2'd0) begin
                    axiRsp.awready <= 1'b1;
                end else begin
                    awDelay <= awDelay - 2'd1;
                end
            end
            if (axiRsp.wready) begin
                axiRsp.wready <= 1'b0;
                writeData     <= axiReq.wdata;
                wGot          <= 1'b1;
                takeDelay(d);
                wDelay <= d;
            end else if (axiReq.wvalid) begin
                if (wDelay == 2'd0) begin
                    axiRsp.wready <= 1'b1;
                end else begin
                    wDelay <= wDelay - 2'd1;
                end
            end
            // response only after both address and data are in
            if (axiRsp.bvalid) begin
                if (axiReq.bready) begin
                    axiRsp.bvalid <= 1'b0;
                    takeDelay(d);
                    bDelay <= d;
                end
            end else if (awGot && wGot) begin
                if (bDelay == 2'd0) begin
                    axiRsp.bvalid  <= 1'b1;
                    axiRsp.bresp   <= AxiRespOkay;
                    mem[writeAddr] <= writeData;
                    awGot          <= 1'b0;
                    wGot           <= 1'b0;
                end else begin
                    bDelay <= bDelay - 2'd1;
                end
            end
        end
    end

endmodule

// File: lc3Checker.sv
module lc3Checker import busPkg::*; (
    input  logic        Clk,
    input  logic        rstN,
    input  axiReq_t     axiReq,
    input  axiRsp_t     axiRsp,
    input  logic [11:0] led,
    input  logic        halted,
    input  logic [11:0] expLed,
    output logic        done,
    output int          writeErrors,
    output int          ledErrors,
    output int          busErrors
);

    timeunit 1ns;
    timeprecision 1ns;

    // cycles watched after the halt for stray requests
    localparam int SettleCycles = 8;

    logic [31:0] expWrites [$];
    axiAddr_t    wrAddr;
    axiData_t    wrData;
    logic        haltSeen;
    int          haltCycles;
    int          writeErrs = 0;
    int          ledErrs = 0;
    int          busErrs = 0;

    assign writeErrors = writeErrs;
    assign ledErrors   = ledErrs;
    assign busErrors   = busErrs;

    // expected writes in bus order with the address in the upper half
    task automatic addExpectedWrite(input logic [15:0] addr, input logic [15:0] data);
        expWrites.push_back({addr, data});
    endtask

    always @(posedge Clk) begin
        logic [31:0] exp;
        if (!rstN) begin
            done       <= 1'b0;
            haltSeen   <= 1'b0;
            haltCycles <= 0;
        end else if (!done) begin
            if (axiReq.awvalid && axiRsp.awready) begin
                wrAddr <= axiReq.awaddr;
            end
            if (axiReq.wvalid && axiRsp.wready) begin
                wrData <= axiReq.wdata;
            end
            // a write counts once its response is taken
            if (axiReq.bready && axiRsp.bvalid) begin
                if (expWrites.size() == 0) begin
                    $display("write of %h to %h at %0t ns was not expected",
                             wrData, wrAddr, $time);
                    writeErrs++;
                end else begin
                    exp = expWrites.pop_front();
                    if (wrAddr !== exp[31:16]) begin
                        $display("** Error at %0t ns: awaddr = %h, expected %h",
                                 $time, wrAddr, exp[31:16]);
                        writeErrs++;
                    end
                    if (wrData !== exp[15:0]) begin
                        $display("** Error at %0t ns: wdata = %h, expected %h",
                                 $time, wrData, exp[15:0]);
                        writeErrs++;
                    end
                end
            end
            if (halted && (axiReq.arvalid || axiReq.awvalid || axiReq.wvalid)) begin
                $display("core raised a bus request after halting at %0t ns", $time);
                busErrs++;
            end
            if (halted && !haltSeen) begin
                haltSeen <= 1'b1;
                if (led !== expLed) begin
                    $display("** Error at %0t ns: led = %h, expected %h", $time, led, expLed);
                    ledErrs++;
                end
                if (expWrites.size() != 0) begin
                    $display("%0d expected writes never happened", expWrites.size());
                    writeErrs += expWrites.size();
                end
            end
            if (haltSeen) begin
                haltCycles <= haltCycles + 1;
                if (haltCycles == SettleCycles - 1) begin
                    done <= 1'b1;
                end
            end
        end
    end

endmodule

// File: lc3Core.sv
module lc3Core import lc3Pkg::*, busPkg::*; (
    input  logic        Clk,
    input  logic        rstN,
    output axiReq_t     axiReq,
    input  axiRsp_t     axiRsp,
    output logic [11:0] led,
    output logic        halted
);

    ctrl_t ctrl;
    word_t ir;
    word_t mar;
    word_t mdr;
    word_t memRdata;
    logic  ben;
    logic  memRead;
    logic  memWrite;
    logic  memDone;

    controlFsm ctrl_i (
        .Clk      (Clk),
        .rstN     (rstN),
        .ir       (ir),
        .ben      (ben),
        .memDone  (memDone),
        .ctrl     (ctrl),
        .memRead  (memRead),
        .memWrite (memWrite),
        .halted   (halted)
    );

    datapath data_i (
        .Clk      (Clk),
        .rstN     (rstN),
        .ctrl     (ctrl),
        .memRdata (memRdata),
        .ben      (ben),
        .led      (led),
        .ir       (ir),
        .mar      (mar),
        .mdr      (mdr)
    );

    memBridge bridge_i (
        .Clk      (Clk),
        .rstN     (rstN),
        .memRead  (memRead),
        .memWrite (memWrite),
        .addr     (mar),
        .wdata    (mdr),
        .memDone  (memDone),
        .memRdata (memRdata),
        .axiReq   (axiReq),
        .axiRsp   (axiRsp)
    );

endmodule

// File: memBridge.sv
module memBridge import lc3Pkg::*, busPkg::*; (
    input  logic    Clk,
    input  logic    rstN,
    input  logic    memRead,
    input  logic    memWrite,
    input  word_t   addr,
    input  word_t   wdata,
    output logic    memDone,
    output word_t   memRdata,
    output axiReq_t axiReq,
    input  axiRsp_t axiRsp
);

    axiAddr_t addrQ;
    axiData_t wdataQ;
    logic     awvalid;
    logic     wvalid;
    logic     bready;
    logic     arvalid;
    logic     rready;
    logic     writeBusy;
    logic     writeFin;

    // each write channel is either already through or handshaking now
    assign writeFin = writeBusy
                    && (!awvalid || axiRsp.awready)
                    && (!wvalid || axiRsp.wready)
                    && (!bready || axiRsp.bvalid);

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            awvalid   <= 1'b0;
            wvalid    <= 1'b0;
            bready    <= 1'b0;
            arvalid   <= 1'b0;
            rready    <= 1'b0;
            writeBusy <= 1'b0;
            memDone   <= 1'b0;
        end else begin
            memDone <= 1'b0;
            if (memWrite) begin
                awvalid   <= 1'b1;
                wvalid    <= 1'b1;
                bready    <= 1'b1;
                writeBusy <= 1'b1;
            end else begin
                if (awvalid && axiRsp.awready) begin
                    awvalid <= 1'b0;
                end
                if (wvalid && axiRsp.wready) begin
                    wvalid <= 1'b0;
                end
                if (bready && axiRsp.bvalid) begin
                    bready <= 1'b0;
                end
                if (writeFin) begin
                    writeBusy <= 1'b0;
                    memDone   <= 1'b1;
                end
            end
            if (memRead) begin
                arvalid <= 1'b1;
                rready  <= 1'b1;
            end else begin
                if (arvalid && axiRsp.arready) begin
                    arvalid <= 1'b0;
                end
                if (rready && axiRsp.rvalid) begin
                    rready  <= 1'b0;
                    memDone <= 1'b1;
                end
            end
        end
    end

    // captured request and read data
    always_ff @(posedge Clk) begin
        if (memRead || memWrite) begin
            addrQ <= addr;
        end
        if (memWrite) begin
            wdataQ <= wdata;
        end
        if (rready && axiRsp.rvalid) begin
            memRdata <= axiRsp.rdata;
        end
    end

    assign axiReq.awaddr  = addrQ;
    assign axiReq.awvalid = awvalid;
    assign axiReq.wdata   = wdataQ;
    assign axiReq.wvalid  = wvalid;
    assign axiReq.bready  = bready;
    assign axiReq.araddr  = addrQ;
    assign axiReq.arvalid = arvalid;
    assign axiReq.rready  = rready;

    awHold: assert property (@(posedge Clk) disable iff (!rstN)
        awvalid && !axiRsp.awready |=> awvalid && $stable(axiReq.awaddr))
        else $error("AW dropped before handshake");

    wHold: assert property (@(posedge Clk) disable iff (!rstN)
        wvalid && !axiRsp.wready |=> wvalid && $stable(axiReq.wdata))
        else $error("W dropped before handshake");

    arHold: assert property (@(posedge Clk) disable iff (!rstN)
        arvalid && !axiRsp.arready |=> arvalid && $stable(axiReq.araddr))
        else $error("AR dropped before handshake");

    // the core has no error path, slave must answer OKAY
    respOkay: assert property (@(posedge Clk) disable iff (!rstN)
        (bready && axiRsp.bvalid |-> axiRsp.bresp == AxiRespOkay)
        and (rready && axiRsp.rvalid |-> axiRsp.rresp == AxiRespOkay))
        else $error("non-OKAY AXI response");

endmodule

// File: controlFsm.sv
module controlFsm import lc3Pkg::*; (
    input  logic  Clk,
    input  logic  rstN,
    input  word_t ir,
    input  logic  ben,
    input  logic  memDone,
    output ctrl_t ctrl,
    output logic  memRead,
    output logic  memWrite,
    output logic  halted
);

    typedef enum logic [4:0] {
        sIdle,
        sFetchAddr,
        sFetchWait,
        sFetchIr,
        sDecode,
        sAlu,
        sBr,
        sJmp,
        sLea,
        sLdPc,
        sLdBase,
        sLdWait,
        sLdReg,
        sStPc,
        sStBase,
        sStData,
        sStWait,
        sPause,
        sHalt
    } state_t;

    state_t  state;
    state_t  stateNext;
    opcode_t opcode;
    logic    reqSent;

    assign opcode = opcode_t'(ir[15:12]);

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            state   <= sIdle;
            reqSent <= 1'b0;
        end else begin
            state <= stateNext;
            // one request per wait state
            if (memDone) begin
                reqSent <= 1'b0;
            end else if (memRead || memWrite) begin
                reqSent <= 1'b1;
            end
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            sIdle:      stateNext = sFetchAddr;
            sFetchAddr: stateNext = sFetchWait;
            sFetchWait: stateNext = memDone ? sFetchIr : sFetchWait;
            sFetchIr:   stateNext = sDecode;
            sDecode: begin
                case (opcode)
                    opAdd, opAnd, opNot: stateNext = sAlu;
                    opBr:    stateNext = sBr;
                    opJmp:   stateNext = sJmp;
                    opLea:   stateNext = sLea;
                    opLd:    stateNext = sLdPc;
                    opLdr:   stateNext = sLdBase;
                    opSt:    stateNext = sStPc;
                    opStr:   stateNext = sStBase;
                    opPause: stateNext = sPause;
                    // unsupported opcodes fall through as no-ops
                    default: stateNext = sFetchAddr;
                endcase
            end
            sLdPc, sLdBase:   stateNext = sLdWait;
            sLdWait:          stateNext = memDone ? sLdReg : sLdWait;
            sStPc, sStBase:   stateNext = sStData;
            sStData:          stateNext = sStWait;
            sStWait:          stateNext = memDone ? sFetchAddr : sStWait;
            sPause, sHalt:    stateNext = sHalt;
            default:          stateNext = sFetchAddr;
        endcase
    end

    always_comb begin
        ctrl = '0;
        case (state)
            sFetchAddr: begin
                ctrl.gatePc = 1'b1;
                ctrl.ldMar  = 1'b1;
                ctrl.ldPc   = 1'b1;
                ctrl.pcMux  = pcMuxInc;
            end
            // MDR follows the read data until memDone
            sFetchWait, sLdWait: begin
                ctrl.ldMdr = 1'b1;
                ctrl.mioEn = 1'b1;
            end
            sFetchIr: begin
                ctrl.gateMdr = 1'b1;
                ctrl.ldIr    = 1'b1;
            end
            sDecode: begin
                ctrl.ldBen = 1'b1;
            end
            sAlu: begin
                ctrl.gateAlu = 1'b1;
                ctrl.ldReg   = 1'b1;
                ctrl.ldCc    = 1'b1;
                ctrl.sr1Mux  = 1'b1;
                ctrl.sr2Mux  = ir[5];
                case (opcode)
                    opAnd:   ctrl.aluk = aluAnd;
                    opNot:   ctrl.aluk = aluNot;
                    default: ctrl.aluk = aluAdd;
                endcase
            end
            sBr: begin
                ctrl.ldPc     = ben;
                ctrl.pcMux    = pcMuxAdder;
                ctrl.addr2Mux = addr2Off9;
            end
            // base register through the adder with a zero offset
            sJmp: begin
                ctrl.ldPc     = 1'b1;
                ctrl.pcMux    = pcMuxAdder;
                ctrl.sr1Mux   = 1'b1;
                ctrl.addr1Mux = 1'b1;
                ctrl.addr2Mux = addr2Zero;
            end
            sLea: begin
                ctrl.gateMarMux = 1'b1;
                ctrl.ldReg      = 1'b1;
                ctrl.addr2Mux   = addr2Off9;
            end
            sLdPc, sStPc: begin
                ctrl.gateMarMux = 1'b1;
                ctrl.ldMar      = 1'b1;
                ctrl.addr2Mux   = addr2Off9;
            end
            sLdBase, sStBase: begin
                ctrl.gateMarMux = 1'b1;
                ctrl.ldMar      = 1'b1;
                ctrl.sr1Mux     = 1'b1;
                ctrl.addr1Mux   = 1'b1;
                ctrl.addr2Mux   = addr2Off6;
            end
            sLdReg: begin
                ctrl.gateMdr = 1'b1;
                ctrl.ldReg   = 1'b1;
                ctrl.ldCc    = 1'b1;
            end
            // source register from IR[11:9] into MDR
            sStData: begin
                ctrl.gateAlu = 1'b1;
                ctrl.aluk    = aluPassA;
                ctrl.ldMdr   = 1'b1;
            end
            sPause: begin
                ctrl.ldLed = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    assign memRead  = ((state == sFetchWait) || (state == sLdWait)) && !reqSent;
    assign memWrite = (state == sStWait) && !reqSent;
    assign halted   = (state == sHalt);

    // a completion only arrives while a wait state is active
    doneInWait: assert property (@(posedge Clk) disable iff (!rstN)
        memDone |-> ((state == sFetchWait) || (state == sLdWait) || (state == sStWait)))
        else $error("memory done outside a wait state");

endmodule

// File: datapath.sv
module datapath import lc3Pkg::*; (
    input  logic        Clk,
    input  logic        rstN,
    input  ctrl_t       ctrl,
    input  word_t       memRdata,
    output logic        ben,
    output logic [11:0] led,
    output word_t       ir,
    output word_t       mar,
    output word_t       mdr
);

    word_t      pc;
    word_t      pcNext;
    word_t      bus;
    word_t      aluOut;
    word_t      aluB;
    word_t      sr1Out;
    word_t      sr2Out;
    word_t      addr1;
    word_t      addr2;
    word_t      adderOut;
    regIdx_t    dr;
    regIdx_t    sr1;
    nzp_t       nzp;
    nzp_t       nzpIn;
    logic [3:0] gates;

    assign gates = {ctrl.gatePc, ctrl.gateMdr, ctrl.gateAlu, ctrl.gateMarMux};

    // shared bus, one driver at a time
    always_comb begin
        case (gates)
            4'b1000: bus = pc;
            4'b0100: bus = mdr;
            4'b0010: bus = aluOut;
            4'b0001: bus = adderOut;
            default: bus = '0;
        endcase
    end

    // register file selects
    assign dr  = ctrl.drMux ? 3'd7 : ir[11:9];
    assign sr1 = ctrl.sr1Mux ? ir[8:6] : ir[11:9];

    regFile regs_i (
        .Clk    (Clk),
        .rstN   (rstN),
        .we     (ctrl.ldReg),
        .dr     (dr),
        .din    (bus),
        .sr1    (sr1),
        .sr2    (ir[2:0]),
        .sr1Out (sr1Out),
        .sr2Out (sr2Out)
    );

    // imm5 or second register
    assign aluB = ctrl.sr2Mux ? {{11{ir[4]}}, ir[4:0]} : sr2Out;

    aluUnit alu_i (
        .a  (sr1Out),
        .b  (aluB),
        .op (ctrl.aluk),
        .y  (aluOut)
    );

    // address adder
    assign addr1 = ctrl.addr1Mux ? sr1Out : pc;

    always_comb begin
        case (ctrl.addr2Mux)
            addr2Off6:  addr2 = {{10{ir[5]}}, ir[5:0]};
            addr2Off9:  addr2 = {{7{ir[8]}}, ir[8:0]};
            addr2Off11: addr2 = {{5{ir[10]}}, ir[10:0]};
            default:    addr2 = '0;
        endcase
    end

    assign adderOut = addr1 + addr2;

    always_comb begin
        case (ctrl.pcMux)
            pcMuxBus:   pcNext = bus;
            pcMuxAdder: pcNext = adderOut;
            default:    pcNext = pc + 16'd1;
        endcase
    end

    assign nzpIn = bus[15] ? nzpN : ((bus == '0) ? nzpZ : nzpP);

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            pc  <= resetPc;
            mar <= '0;
            mdr <= '0;
            ir  <= '0;
            led <= '0;
            nzp <= nzpZ;
            ben <= 1'b0;
        end else begin
            if (ctrl.ldPc) begin
                pc <= pcNext;
            end
            if (ctrl.ldMar) begin
                mar <= bus;
            end
            if (ctrl.ldMdr) begin
                mdr <= ctrl.mioEn ? memRdata : bus;
            end
            if (ctrl.ldIr) begin
                ir <= bus;
            end
            if (ctrl.ldLed) begin
                led <= ir[11:0];
            end
            if (ctrl.ldCc) begin
                nzp <= nzpIn;
            end
            // branch enable from the n, z, p bits of the instruction
            if (ctrl.ldBen) begin
                ben <= |(ir[11:9] & nzp);
            end
        end
    end

    busOneDriver: assert property (@(posedge Clk) disable iff (!rstN) $onehot0(gates))
        else $error("more than one bus gate active");

endmodule

// File: aluUnit.sv
module aluUnit import lc3Pkg::*; (
    input  word_t  a,
    input  word_t  b,
    input  aluOp_t op,
    output word_t  y
);

    always_comb begin
        case (op)
            aluAdd: begin
                y = a + b;
            end
            aluAnd: begin
                y = a & b;
            end
            aluNot: begin
                y = ~a;
            end
            // used for store data on its way to MDR
            default: begin
                y = a;
            end
        endcase
    end

endmodule

// File: regFile.sv
module regFile import lc3Pkg::*; (
    input  logic    Clk,
    input  logic    rstN,
    input  logic    we,
    input  regIdx_t dr,
    input  word_t   din,
    input  regIdx_t sr1,
    input  regIdx_t sr2,
    output word_t   sr1Out,
    output word_t   sr2Out
);

    word_t regs [RegCount];

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            for (int i = 0; i < RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[dr] <= din;
        end
    end

    // combinational reads, new value visible the cycle after the write
    assign sr1Out = regs[sr1];
    assign sr2Out = regs[sr2];

endmodule

// File: busPkg.sv
package busPkg;

    localparam int AxiAddrWidth = 16;
    localparam int AxiDataWidth = 16;
    localparam logic [1:0] AxiRespOkay = 2'b00;

    typedef logic [AxiAddrWidth-1:0] axiAddr_t;
    typedef logic [AxiDataWidth-1:0] axiData_t;
    typedef logic [1:0] axiResp_t;

    // master side, no write strobes since every access is a full word
    typedef struct packed {
        axiAddr_t awaddr;
        logic     awvalid;
        axiData_t wdata;
        logic     wvalid;
        logic     bready;
        axiAddr_t araddr;
        logic     arvalid;
        logic     rready;
    } axiReq_t;

    typedef struct packed {
        logic     awready;
        logic     wready;
        logic     bvalid;
        axiResp_t bresp;
        logic     arready;
        logic     rvalid;
        axiData_t rdata;
        axiResp_t rresp;
    } axiRsp_t;

endpackage

// File: lc3Pkg.sv
package lc3Pkg;

    localparam int WordWidth = 16;
    localparam int RegCount = 8;

    typedef logic [WordWidth-1:0] word_t;
    typedef logic [2:0] regIdx_t;
    // condition codes in N, Z, P order
    typedef logic [2:0] nzp_t;

    localparam word_t resetPc = 16'h3000;

    localparam nzp_t nzpN = 3'b100;
    localparam nzp_t nzpZ = 3'b010;
    localparam nzp_t nzpP = 3'b001;

    // address adder and PC source selects
    localparam logic [1:0] addr2Zero = 2'd0;
    localparam logic [1:0] addr2Off6 = 2'd1;
    localparam logic [1:0] addr2Off9 = 2'd2;
    localparam logic [1:0] addr2Off11 = 2'd3;
    localparam logic [1:0] pcMuxInc = 2'd0;
    localparam logic [1:0] pcMuxBus = 2'd1;
    localparam logic [1:0] pcMuxAdder = 2'd2;

    typedef enum logic [3:0] {
        opBr    = 4'b0000,
        opAdd   = 4'b0001,
        opLd    = 4'b0010,
        opSt    = 4'b0011,
        opJsr   = 4'b0100,
        opAnd   = 4'b0101,
        opLdr   = 4'b0110,
        opStr   = 4'b0111,
        opRti   = 4'b1000,
        opNot   = 4'b1001,
        opLdi   = 4'b1010,
        opSti   = 4'b1011,
        opJmp   = 4'b1100,
        opPause = 4'b1101,
        opLea   = 4'b1110,
        opTrap  = 4'b1111
    } opcode_t;

    typedef enum logic [1:0] {
        aluAdd   = 2'd0,
        aluAnd   = 2'd1,
        aluNot   = 2'd2,
        aluPassA = 2'd3
    } aluOp_t;

    typedef struct packed {
        logic       ldMar;
        logic       ldMdr;
        logic       ldIr;
        logic       ldBen;
        logic       ldCc;
        logic       ldReg;
        logic       ldPc;
        logic       ldLed;
        logic       gatePc;
        logic       gateMdr;
        logic       gateAlu;
        logic       gateMarMux;
        logic       drMux;
        logic       sr1Mux;
        logic       sr2Mux;
        logic       addr1Mux;
        logic       mioEn;
        logic [1:0] addr2Mux;
        logic [1:0] pcMux;
        aluOp_t     aluk;
    } ctrl_t;

endpackage
